// ==== common/snakePkg.sv ====
// shared screen, block, trail, colour and state definitions for the snake game RTL and testbench
package snakePkg;

    // an 8-bit screen column and a 7-bit screen row
    typedef logic [7:0] xCoord_t;
    typedef logic [6:0] yCoord_t;
    // 3-bit rgb, one bit per channel
    typedef logic [2:0] colour_t;
    // pixel offset inside one block
    typedef logic [3:0] blockCount_t;
    // body segment number
    typedef logic [2:0] segIndex_t;

    typedef enum logic [2:0] {none, right, down, up, left} direction_t;

    // per-frame order of the sequencer
    typedef enum logic [3:0] {
        idle, drawApple, appleRow, drawBody, bodyRow, bodyDone, waitErase,
        eraseBody, eraseRow, eraseDone, checkHit, stepHead, shiftTrail, gameEnd
    } drawState_t;

    // framebuffer size
    localparam int screenWidth = 160;
    localparam int screenHeight = 120;

    // side of every drawn block
    localparam int blockSize = 10;
    localparam int segmentCount = 6;
    // one trail entry per head step, ten steps per segment
    localparam int trailDepth = segmentCount * blockSize;
    // nearer segments can never be touched by the head
    localparam int collideFirst = 3;

    // fixed apple corner
    localparam xCoord_t appleX = 8'd30;
    localparam yCoord_t appleY = 7'd30;
    localparam colour_t appleColour = 3'b100;
    localparam colour_t eraseColour = 3'b000;

    // head start; the body hangs straight down from it
    localparam xCoord_t startX = 8'd80;
    localparam yCoord_t startY = 7'd60;

endpackage

// ==== hw/directionDecode.sv ====
// turns the active-low direction keys into the registered held direction of the snake
`timescale 1ns/1ns

module directionDecode
(
    input  logic                    Clock,
    input  logic                    reset,
    input  logic [3:0]              keys,
    output snakePkg::direction_t    heldDir
);

    snakePkg::direction_t keyDir;

    // priority decode, lowest pressed key wins
    always_comb
    begin
        if (!keys[0])
            keyDir = snakePkg::right;
        else if (!keys[1])
            keyDir = snakePkg::down;
        else if (!keys[2])
            keyDir = snakePkg::up;
        else if (!keys[3])
            keyDir = snakePkg::left;
        else
            keyDir = snakePkg::none;
    end

    // all keys released keeps the last direction
    always_ff @(posedge Clock)
    begin
        if (reset)
            heldDir <= snakePkg::none;
        else if (~&keys)
            heldDir <= keyDir;
    end

endmodule

// ==== snake/snakeBody.sv ====
// head position counters and the past-position trail, with segment corner lookup for drawing
`timescale 1ns/1ns

module snakeBody
(
    input  logic                    Clock,
    input  logic                    reset,
    input  snakePkg::direction_t    heldDir,
    input  logic                    stepHead,
    input  logic                    shiftTrail,
    input  snakePkg::segIndex_t     segSelect,
    output snakePkg::xCoord_t       segX,
    output snakePkg::yCoord_t       segY,
    output snakePkg::xCoord_t       headX,
    output snakePkg::yCoord_t       headY,
    output snakePkg::xCoord_t       bodyX [snakePkg::collideFirst:snakePkg::segmentCount-1],
    output snakePkg::yCoord_t       bodyY [snakePkg::collideFirst:snakePkg::segmentCount-1]
);

    // entry 0 is the newest head position
    snakePkg::xCoord_t trailX [snakePkg::trailDepth];
    snakePkg::yCoord_t trailY [snakePkg::trailDepth];

    // head moves one pixel per step, wrapping at the coordinate width
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            headX <= snakePkg::startX;
            headY <= snakePkg::startY;
        end
        else if (stepHead)
        begin
            case (heldDir)
                snakePkg::right: headX <= headX + 1'b1;
                snakePkg::left:  headX <= headX - 1'b1;
                snakePkg::down:  headY <= headY + 1'b1;
                snakePkg::up:    headY <= headY - 1'b1;
                default:         ;
            endcase
        end
    end

    // ten entries per segment, segment k one block below the head at start
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            for (int i = 0; i < snakePkg::trailDepth; i++)
            begin
                trailX[i] <= snakePkg::startX;
                trailY[i] <= snakePkg::yCoord_t'(snakePkg::startY +
                    (i / snakePkg::blockSize) * snakePkg::blockSize);
            end
        end
        else if (shiftTrail)
        begin
            trailX[0] <= headX;
            trailY[0] <= headY;
            // oldest entry falls off the end
            for (int i = 1; i < snakePkg::trailDepth; i++)
            begin
                trailX[i] <= trailX[i-1];
                trailY[i] <= trailY[i-1];
            end
        end
    end

    // drawn segment corner, out-of-range selects fall back to the head entry
    always_comb
    begin
        segX = trailX[0];
        segY = trailY[0];
        if (segSelect < snakePkg::segmentCount)
        begin
            segX = trailX[segSelect * snakePkg::blockSize];
            segY = trailY[segSelect * snakePkg::blockSize];
        end
    end

    // taps for the collision test
    for (genvar k = snakePkg::collideFirst; k < snakePkg::segmentCount; k++)
    begin : bodyTap
        assign bodyX[k] = trailX[k * snakePkg::blockSize];
        assign bodyY[k] = trailY[k * snakePkg::blockSize];
    end

endmodule

// ==== snake/collisionCheck.sv ====
// combinational test of the head block against the far body segments in the held direction
`timescale 1ns/1ns

module collisionCheck
(
    input  snakePkg::direction_t    heldDir,
    input  snakePkg::xCoord_t       headX,
    input  snakePkg::yCoord_t       headY,
    input  snakePkg::xCoord_t       bodyX [snakePkg::collideFirst:snakePkg::segmentCount-1],
    input  snakePkg::yCoord_t       bodyY [snakePkg::collideFirst:snakePkg::segmentCount-1],
    output logic                    hit
);

    // columns overlap when the corners are less than a block apart either way
    function automatic logic nearX(snakePkg::xCoord_t a, snakePkg::xCoord_t b);
        nearX = (snakePkg::xCoord_t'(a - b) < snakePkg::blockSize) ||
                (snakePkg::xCoord_t'(b - a) < snakePkg::blockSize);
    endfunction

    // same test on rows
    function automatic logic nearY(snakePkg::yCoord_t a, snakePkg::yCoord_t b);
        nearY = (snakePkg::yCoord_t'(a - b) < snakePkg::blockSize) ||
                (snakePkg::yCoord_t'(b - a) < snakePkg::blockSize);
    endfunction

    // head edge must sit flush against the segment on the side it is heading to
    always_comb
    begin
        hit = 1'b0;
        for (int k = snakePkg::collideFirst; k < snakePkg::segmentCount; k++)
        begin
            case (heldDir)
                snakePkg::up:
                    if (headY == snakePkg::yCoord_t'(bodyY[k] + snakePkg::blockSize) &&
                        nearX(headX, bodyX[k]))
                        hit = 1'b1;
                snakePkg::down:
                    if (snakePkg::yCoord_t'(headY + snakePkg::blockSize) == bodyY[k] &&
                        nearX(headX, bodyX[k]))
                        hit = 1'b1;
                snakePkg::left:
                    if (headX == snakePkg::xCoord_t'(bodyX[k] + snakePkg::blockSize) &&
                        nearY(headY, bodyY[k]))
                        hit = 1'b1;
                snakePkg::right:
                    if (snakePkg::xCoord_t'(headX + snakePkg::blockSize) == bodyX[k] &&
                        nearY(headY, bodyY[k]))
                        hit = 1'b1;
                // standing still never collides
                default: ;
            endcase
        end
    end

endmodule

// ==== hw/frameSequencer.sv ====
// per-frame draw/erase FSM of the snake game, emits one framebuffer pixel per clock
`timescale 1ns/1ns

module frameSequencer
#(
    parameter int tickBits = 20
)
(
    input  logic                    Clock,
    input  logic                    reset,
    input  logic                    go,
    input  snakePkg::colour_t       colourSel,
    input  logic                    hit,
    input  snakePkg::xCoord_t       segX,
    input  snakePkg::yCoord_t       segY,
    output logic                    stepHead,
    output logic                    shiftTrail,
    output snakePkg::segIndex_t     segSelect,
    output logic                    plot,
    output snakePkg::xCoord_t       pixelX,
    output snakePkg::yCoord_t       pixelY,
    output snakePkg::colour_t       pixelColour,
    output logic                    gameOver
);

    logic [tickBits-1:0] tickCount;
    logic tick;
    snakePkg::drawState_t state;
    snakePkg::drawState_t nextState;
    // pixel offsets inside the current block
    snakePkg::blockCount_t countX;
    snakePkg::blockCount_t countY;
    snakePkg::segIndex_t segCount;
    logic lastCol;
    logic lastRow;
    logic lastSeg;

    // free-running frame tick, sets the animation speed
    always_ff @(posedge Clock)
    begin
        if (reset)
            tickCount <= '0;
        else
            tickCount <= tickCount + 1'b1;
    end

    assign tick = (tickCount == '0);
    assign lastCol = (countX == snakePkg::blockCount_t'(snakePkg::blockSize - 1));
    assign lastRow = (countY == snakePkg::blockCount_t'(snakePkg::blockSize - 1));
    assign lastSeg = (segCount == snakePkg::segIndex_t'(snakePkg::segmentCount - 1));

    always_comb
    begin
        nextState = state;
        case (state)
            snakePkg::idle:       if (go && tick) nextState = snakePkg::drawApple;
            snakePkg::drawApple:  if (lastCol) nextState = snakePkg::appleRow;
            snakePkg::appleRow:   nextState = lastRow ? snakePkg::drawBody : snakePkg::drawApple;
            snakePkg::drawBody:   if (lastCol) nextState = snakePkg::bodyRow;
            snakePkg::bodyRow:    nextState = lastRow ? snakePkg::bodyDone : snakePkg::drawBody;
            snakePkg::bodyDone:   nextState = lastSeg ? snakePkg::waitErase : snakePkg::drawBody;
            // body stays on screen for one tick
            snakePkg::waitErase:  if (tick) nextState = snakePkg::eraseBody;
            snakePkg::eraseBody:  if (lastCol) nextState = snakePkg::eraseRow;
            snakePkg::eraseRow:   nextState = lastRow ? snakePkg::eraseDone : snakePkg::eraseBody;
            snakePkg::eraseDone:  nextState = lastSeg ? snakePkg::checkHit : snakePkg::eraseBody;
            // hit is sampled before the head moves
            snakePkg::checkHit:   nextState = hit ? snakePkg::gameEnd : snakePkg::stepHead;
            snakePkg::stepHead:   nextState = snakePkg::shiftTrail;
            snakePkg::shiftTrail: nextState = snakePkg::idle;
            // no way out short of reset
            snakePkg::gameEnd:    nextState = snakePkg::gameEnd;
            default:              nextState = snakePkg::idle;
        endcase
    end

    always_ff @(posedge Clock)
    begin
        if (reset)
            state <= snakePkg::idle;
        else
            state <= nextState;
    end

    // block raster counters and segment counter, all back at zero after each run
    always_ff @(posedge Clock)
    begin
        if (reset)
        begin
            countX <= '0;
            countY <= '0;
            segCount <= '0;
        end
        else
        begin
            case (state)
                snakePkg::drawApple, snakePkg::drawBody, snakePkg::eraseBody:
                    if (!lastCol)
                        countX <= countX + 1'b1;
                snakePkg::appleRow, snakePkg::bodyRow, snakePkg::eraseRow:
                begin
                    countX <= '0;
                    countY <= lastRow ? '0 : countY + 1'b1;
                end
                snakePkg::bodyDone, snakePkg::eraseDone:
                    segCount <= lastSeg ? '0 : segCount + 1'b1;
                default: ;
            endcase
        end
    end

    // sticky once a hit is seen
    always_ff @(posedge Clock)
    begin
        if (reset)
            gameOver <= 1'b0;
        else if (state == snakePkg::checkHit && hit)
            gameOver <= 1'b1;
    end

    // body strobes straight from the state
    assign stepHead = (state == snakePkg::stepHead);
    assign shiftTrail = (state == snakePkg::shiftTrail);
    assign segSelect = segCount;

    assign plot = (state == snakePkg::drawApple) || (state == snakePkg::drawBody) ||
                  (state == snakePkg::eraseBody);

    // pixel is the block corner plus the raster offsets
    always_comb
    begin
        if (state == snakePkg::drawApple)
        begin
            pixelX = snakePkg::appleX + snakePkg::xCoord_t'(countX);
            pixelY = snakePkg::appleY + snakePkg::yCoord_t'(countY);
            pixelColour = snakePkg::appleColour;
        end
        else
        begin
            pixelX = segX + snakePkg::xCoord_t'(countX);
            pixelY = segY + snakePkg::yCoord_t'(countY);
            // erase pass paints black over the same blocks
            pixelColour = (state == snakePkg::drawBody) ? colourSel : snakePkg::eraseColour;
        end
    end

endmodule

// ==== hw/snakeGame.sv ====
// snake game top level, joins key decode, snake body, collision test and pixel sequencer
`timescale 1ns/1ns

module snakeGame
#(
    parameter int tickBits = 20
)
(
    input  logic                Clock,
    input  logic                reset,
    input  logic [3:0]          keys,
    input  logic                go,
    input  snakePkg::colour_t   colourSel,
    output logic                plot,
    output snakePkg::xCoord_t   pixelX,
    output snakePkg::yCoord_t   pixelY,
    output snakePkg::colour_t   pixelColour,
    output logic                gameOver
);

    snakePkg::direction_t heldDir;
    logic stepHead;
    logic shiftTrail;
    logic hit;
    snakePkg::segIndex_t segSelect;
    snakePkg::xCoord_t segX;
    snakePkg::yCoord_t segY;
    snakePkg::xCoord_t headX;
    snakePkg::yCoord_t headY;
    // corners of the segments that take part in the collision test
    snakePkg::xCoord_t bodyX [snakePkg::collideFirst:snakePkg::segmentCount-1];
    snakePkg::yCoord_t bodyY [snakePkg::collideFirst:snakePkg::segmentCount-1];

    // decode stage
    directionDecode decode (.Clock(Clock), .reset(reset), .keys(keys), .heldDir(heldDir));

    // execute stage
    snakeBody body (.Clock(Clock), .reset(reset), .heldDir(heldDir), .stepHead(stepHead),
        .shiftTrail(shiftTrail), .segSelect(segSelect), .segX(segX), .segY(segY),
        .headX(headX), .headY(headY), .bodyX(bodyX), .bodyY(bodyY));

    collisionCheck collide (.heldDir(heldDir), .headX(headX), .headY(headY),
        .bodyX(bodyX), .bodyY(bodyY), .hit(hit));

    // result stage, emits the pixels
    frameSequencer #(.tickBits(tickBits)) sequencer (.Clock(Clock), .reset(reset), .go(go),
        .colourSel(colourSel), .hit(hit), .segX(segX), .segY(segY), .stepHead(stepHead),
        .shiftTrail(shiftTrail), .segSelect(segSelect), .plot(plot), .pixelX(pixelX),
        .pixelY(pixelY), .pixelColour(pixelColour), .gameOver(gameOver));

endmodule

// ==== sim/snakeGame_sva.sv ====
// assertions on the frame sequencer outputs, bound into every sequencer instance in simulation
`timescale 1ns/1ns

module snakeGameSva
(
    input logic                 Clock,
    input logic                 reset,
    input logic                 plot,
    input logic                 gameOver,
    input logic                 stepHead,
    input logic                 shiftTrail,
    input snakePkg::xCoord_t    pixelX
);

    // ended game draws nothing
    noPlotAfterEnd: assert property (@(posedge Clock) disable iff (reset)
        !(plot && gameOver))
        else $error("plot is high while gameOver is high");

    // head step and trail shift in separate cycles
    strobesApart: assert property (@(posedge Clock) disable iff (reset)
        !(stepHead && shiftTrail))
        else $error("stepHead and shiftTrail are high together");

    // plotted pixels stay on screen
    pixelOnScreen: assert property (@(posedge Clock) disable iff (reset)
        plot |-> (pixelX < snakePkg::screenWidth))
        else $error("pixelX %0d is off screen", pixelX);

endmodule

bind frameSequencer snakeGameSva sequencerChecks (.Clock(Clock), .reset(reset), .plot(plot),
    .gameOver(gameOver), .stepHead(stepHead), .shiftTrail(shiftTrail), .pixelX(pixelX));

// ==== sim/snakeGameTb.sv ====
// testbench for the snake game, plays a table of frames and checks every pixel against a model
`timescale 1ns/1ns

module snakeGameTb;

    localparam int rowCount = 6;
    // roughly eight frames of cycles per row, far above a real frame
    localparam int cycleLimit = rowCount * 1500 * 8;

    // one table row: inputs to hold, frames to play, hit due on its last frame
    typedef struct packed {
        logic [3:0] keys;
        logic go;
        snakePkg::colour_t colour;
        logic [7:0] frames;
        logic hit;
    } frameRow_t;

    logic Clock = 1'b0;
    logic reset;
    logic [3:0] keys;
    logic go;
    snakePkg::colour_t colourSel;
    logic plot;
    snakePkg::xCoord_t pixelX;
    snakePkg::yCoord_t pixelY;
    snakePkg::colour_t pixelColour;
    logic gameOver;

    frameRow_t frameTable [rowCount];
    // model of held direction, head and position trail
    snakePkg::direction_t modelDir;
    snakePkg::xCoord_t headX;
    snakePkg::yCoord_t headY;
    snakePkg::xCoord_t trailX [snakePkg::trailDepth];
    snakePkg::yCoord_t trailY [snakePkg::trailDepth];
    int checks = 0;
    int errors = 0;
    int cycles = 0;
    // row whose inputs go in at the first pixel of the next frame
    int pendingRow = -1;
    logic havePixel = 1'b0;
    logic playing = 1'b0;
    logic gameEnded = 1'b0;

    snakeGame #(.tickBits(3)) dut (.Clock(Clock), .reset(reset), .keys(keys), .go(go),
        .colourSel(colourSel), .plot(plot), .pixelX(pixelX), .pixelY(pixelY),
        .pixelColour(pixelColour), .gameOver(gameOver));

    always #20 Clock = ~Clock;

    // run limit
    always @(posedge Clock)
    begin
        cycles++;
        if (cycles > cycleLimit)
        begin
            $display("timeout: the test did not finish within %0d cycles", cycleLimit);
            $display("Regression failed");
            $finish;
        end
    end

    task automatic compareX(snakePkg::xCoord_t got, snakePkg::xCoord_t exp, string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("** Error at %0t: %s pixelX %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic compareY(snakePkg::yCoord_t got, snakePkg::yCoord_t exp, string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("** Error at %0t: %s pixelY %0d, expected %0d", $time, what, got, exp);
        end
    endtask

    task automatic compareColour(snakePkg::colour_t got, snakePkg::colour_t exp, string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("** Error at %0t: %s colour %b, expected %b", $time, what, got, exp);
        end
    endtask

    task automatic compareBit(logic got, logic exp, string what);
        checks++;
        if (got !== exp)
        begin
            errors++;
            $display("** Error at %0t: %s is %b, expected %b", $time, what, got, exp);
        end
    endtask

    // drive a row, model direction follows the lowest pressed key
    task automatic applyRow(int r);
        keys = frameTable[r].keys;
        go = frameTable[r].go;
        colourSel = frameTable[r].colour;
        if (!keys[0])
            modelDir = snakePkg::right;
        else if (!keys[1])
            modelDir = snakePkg::down;
        else if (!keys[2])
            modelDir = snakePkg::up;
        else if (!keys[3])
            modelDir = snakePkg::left;
    endtask

    // next plotted pixel, sampled mid-cycle
    task automatic checkPixel(snakePkg::xCoord_t ex, snakePkg::yCoord_t ey,
        snakePkg::colour_t ec, string what);
        while (!havePixel)
        begin
            @(negedge Clock);
            havePixel = plot;
        end
        havePixel = 1'b0;
        compareX(pixelX, ex, what);
        compareY(pixelY, ey, what);
        compareColour(pixelColour, ec, what);
        // frame has started, safe to change keys and colour
        if (pendingRow >= 0)
        begin
            applyRow(pendingRow);
            pendingRow = -1;
        end
    endtask

    // raster order, row by row
    task automatic checkBlock(snakePkg::xCoord_t cx, snakePkg::yCoord_t cy,
        snakePkg::colour_t c, string what);
        for (int y = 0; y < snakePkg::blockSize; y++)
            for (int x = 0; x < snakePkg::blockSize; x++)
                checkPixel(cx + snakePkg::xCoord_t'(x), cy + snakePkg::yCoord_t'(y), c, what);
    endtask

    // flush on the heading side and overlapping across it, positions before the step
    function automatic logic modelHit();
        logic found;
        logic xNear;
        logic yNear;
        int bx;
        int by;
        int dx;
        int dy;
        found = 1'b0;
        for (int k = snakePkg::collideFirst; k < snakePkg::segmentCount; k++)
        begin
            bx = trailX[k * snakePkg::blockSize];
            by = trailY[k * snakePkg::blockSize];
            dx = (int'(headX) - bx) & 255;
            dy = (int'(headY) - by) & 127;
            xNear = (dx < snakePkg::blockSize) || (dx > 256 - snakePkg::blockSize);
            yNear = (dy < snakePkg::blockSize) || (dy > 128 - snakePkg::blockSize);
            case (modelDir)
                snakePkg::up:
                    found |= (int'(headY) == ((by + snakePkg::blockSize) & 127)) && xNear;
                snakePkg::down:
                    found |= (by == ((int'(headY) + snakePkg::blockSize) & 127)) && xNear;
                snakePkg::left:
                    found |= (int'(headX) == ((bx + snakePkg::blockSize) & 255)) && yNear;
                snakePkg::right:
                    found |= (bx == ((int'(headX) + snakePkg::blockSize) & 255)) && yNear;
                default: ;
            endcase
        end
        return found;
    endfunction

    // one pixel step, then the new head enters the trail
    task automatic stepModel();
        case (modelDir)
            snakePkg::right: headX = headX + 1'b1;
            snakePkg::left:  headX = headX - 1'b1;
            snakePkg::down:  headY = headY + 1'b1;
            snakePkg::up:    headY = headY - 1'b1;
            default: ;
        endcase
        for (int i = snakePkg::trailDepth - 1; i > 0; i--)
        begin
            trailX[i] = trailX[i - 1];
            trailY[i] = trailY[i - 1];
        end
        trailX[0] = headX;
        trailY[0] = headY;
    endtask

    // apple, body, erase, then the hit outcome
    task automatic playFrame(int r, logic lastFrame);
        logic hitNow;
        checkBlock(snakePkg::appleX, snakePkg::appleY, snakePkg::appleColour, "apple");
        for (int k = 0; k < snakePkg::segmentCount; k++)
            checkBlock(trailX[k * snakePkg::blockSize], trailY[k * snakePkg::blockSize],
                frameTable[r].colour, "body");
        for (int k = 0; k < snakePkg::segmentCount; k++)
            checkBlock(trailX[k * snakePkg::blockSize], trailY[k * snakePkg::blockSize],
                snakePkg::eraseColour, "erase");
        hitNow = modelHit();
        compareBit(hitNow, lastFrame && frameTable[r].hit, "model hit against table");
        // either gameOver rises or the next frame's first pixel shows up
        for (int n = 0; n < 40 && !gameOver && !havePixel; n++)
        begin
            @(negedge Clock);
            havePixel = plot;
        end
        compareBit(gameOver, hitNow, "gameOver");
        if (hitNow)
        begin
            gameEnded = 1'b1;
            repeat (100)
            begin
                @(negedge Clock);
                compareBit(plot, 1'b0, "plot after game over");
            end
        end
        else
            stepModel();
    endtask

    initial
    begin
        // idle, right, all keys (right wins), released, up, down+left (down wins, reversal)
        frameTable[0] = '{4'b1111, 1'b0, 3'b010, 8'd0, 1'b0};
        frameTable[1] = '{4'b1110, 1'b1, 3'b010, 8'd3, 1'b0};
        frameTable[2] = '{4'b0000, 1'b1, 3'b001, 8'd2, 1'b0};
        frameTable[3] = '{4'b1111, 1'b1, 3'b011, 8'd2, 1'b0};
        frameTable[4] = '{4'b1011, 1'b1, 3'b110, 8'd3, 1'b0};
        frameTable[5] = '{4'b0101, 1'b1, 3'b111, 8'd4, 1'b1};
        reset = 1'b1;
        keys = 4'hf;
        go = 1'b0;
        colourSel = '0;
        // start layout, body hangs straight down from the head
        modelDir = snakePkg::none;
        headX = snakePkg::startX;
        headY = snakePkg::startY;
        for (int i = 0; i < snakePkg::trailDepth; i++)
        begin
            trailX[i] = snakePkg::startX;
            trailY[i] = snakePkg::startY + snakePkg::yCoord_t'((i / 10) * 10);
        end
        repeat (3) @(negedge Clock);
        reset = 1'b0;
        for (int r = 0; r < rowCount && !gameEnded; r++)
        begin
            if (!frameTable[r].go)
            begin
                applyRow(r);
                repeat (40)
                begin
                    @(negedge Clock);
                    compareBit(plot, 1'b0, "plot before go");
                    compareBit(gameOver, 1'b0, "gameOver before go");
                end
            end
            else
            begin
                // mid-game rows wait for the next frame to begin
                if (playing)
                    pendingRow = r;
                else
                    applyRow(r);
                playing = 1'b1;
                for (int f = 0; f < frameTable[r].frames && !gameEnded; f++)
                    playFrame(r, f == frameTable[r].frames - 1);
            end
            $display("row %0d done: %0d checks, %0d errors so far", r, checks, errors);
        end
        if (!gameEnded)
        begin
            errors++;
            $display("the game did not end on the reversal row");
        end
        $display("%0d checks, %0d errors", checks, errors);
        if (errors == 0)
            $display("Regression passed");
        else
            $display("Regression failed");
        $finish;
    end

endmodule

// ==== sources.f ====
common/snakePkg.sv
hw/directionDecode.sv
snake/snakeBody.sv
snake/collisionCheck.sv
hw/frameSequencer.sv
hw/snakeGame.sv
sim/snakeGame_sva.sv
sim/snakeGameTb.sv

// ==== Makefile ====
SOURCES := $(shell grep -v '^+' sources.f)

.PHONY: run clean

run: obj_dir/VsnakeGameTb
	obj_dir/VsnakeGameTb | tee /dev/stderr | grep -q "Regression passed"

obj_dir/VsnakeGameTb: sources.f $(SOURCES)
	verilator --binary --timing --assert -Wno-fatal --top-module snakeGameTb -f sources.f

clean:
	rm -rf obj_dir
